/* job_evaluator.sv */
`timescale 1ns/10ps

module job_evaluator (
    input  logic                         clk,
    input  logic                         inf,
    input  stock_pkg::job_t              pop_job,
    input  logic                         empty,
    output logic                         pop_ready,
    output logic                         dram_wr_valid,
    output logic [stock_pkg::ADDR_W-1:0] dram_wr_addr,
    output stock_pkg::record_t           dram_wr_data,
    output logic                         out_valid,
    output stock_pkg::warn_t             warn_msg,
    output logic                         complete
);

    import stock_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_INDEX,
        S_UPDATE
    } state_t;

    state_t                  state;
    logic [2:0]              step;
    job_t                    job_r;
    job_t                    cur_job;
    logic                    pop;
    logic                    fire;
    logic [3:0][INDEX_W-1:0] rec_idx;
    logic [INDEX_W-1:0]      s_max, s_2, s_3, s_min;
    logic [INDEX_W+1:0]      sum_all;
    logic [INDEX_W-1:0]      result_r;
    logic [INDEX_W-1:0]      thresh_r;
    logic [3:0][INDEX_W+1:0] upd_sum;
    logic [3:0][INDEX_W-1:0] upd_idx;
    logic [3:0]              clamp;
    logic                    data_flag;
    logic                    date_before;
    logic                    date_warn, data_warn, risk_warn;
    warn_t                   warn_nx;

    assign pop_ready = (state == S_IDLE);
    assign pop       = pop_ready && !empty;
    // Check_Valid_Date resolves straight from the queue head
    assign cur_job   = (state == S_IDLE) ? pop_job : job_r;
    assign rec_idx   = {job_r.rec.index_d, job_r.rec.index_c,
                        job_r.rec.index_b, job_r.rec.index_a};

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state <= S_IDLE;
            step  <= 3'd0;
        end else begin
            step <= step + 3'd1;
            case (state)
                S_IDLE: begin
                    step <= 3'd1;
                    if (pop && pop_job.action == Index_Check)
                        state <= S_INDEX;
                    else if (pop && pop_job.action == Update)
                        state <= S_UPDATE;
                end
                S_INDEX: begin
                    if (step == 3'd5)
                        state <= S_IDLE;
                end
                S_UPDATE: begin
                    if (step == 3'd2)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            job_r <= pop_job;
    end

    assign fire = (pop && pop_job.action != Index_Check && pop_job.action != Update)
               || (state == S_INDEX && step == 3'd5)
               || (state == S_UPDATE && step == 3'd2);

    // ====================
    // Index check
    // ====================
    sort4_pipe sort_i (
        .clk     (clk),
        .in_a    (rec_idx[0]),
        .in_b    (rec_idx[1]),
        .in_c    (rec_idx[2]),
        .in_d    (rec_idx[3]),
        .out_max (s_max),
        .out_2   (s_2),
        .out_3   (s_3),
        .out_min (s_min)
    );

    assign sum_all = ({2'b00, s_max} + {2'b00, s_2}) + ({2'b00, s_3} + {2'b00, s_min});

    // Sorter output settles at step 4
    always_ff @(posedge clk) begin
        case (job_r.formula)
            Formula_A: result_r <= sum_all[INDEX_W+1:2];
            Formula_B: result_r <= s_max - s_min;
            Formula_C: result_r <= s_min;
            default:   result_r <= '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!(job_r.mode inside {Insensitive, Normal, Sensitive}))
            thresh_r <= '0;
        else if (job_r.formula inside {Formula_A, Formula_C})
            thresh_r <= THRESH_AC[job_r.mode];
        else if (job_r.formula == Formula_B)
            thresh_r <= THRESH_B[job_r.mode];
        else
            thresh_r <= '0;
    end

    // ====================
    // Update
    // ====================
    // Top two bits of the sum flag underflow and overflow
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            upd_sum[i] = {2'b00, rec_idx[i]}
                       + {{2{job_r.delta[i][INDEX_W-1]}}, job_r.delta[i]};
            clamp[i]   = upd_sum[i][INDEX_W+1] | upd_sum[i][INDEX_W];
            if (upd_sum[i][INDEX_W+1])
                upd_idx[i] = '0;
            else if (upd_sum[i][INDEX_W])
                upd_idx[i] = INDEX_MAX;
            else
                upd_idx[i] = upd_sum[i][INDEX_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            dram_wr_valid <= 1'b0;
        end else begin
            dram_wr_valid <= (state == S_UPDATE) && (step == 3'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_UPDATE && step == 3'd1) begin
            dram_wr_addr         <= rec_addr(job_r.data_no);
            dram_wr_data.index_a <= upd_idx[0];
            dram_wr_data.index_b <= upd_idx[1];
            dram_wr_data.index_c <= upd_idx[2];
            dram_wr_data.index_d <= upd_idx[3];
            dram_wr_data.month   <= 8'(job_r.month);
            dram_wr_data.day     <= 8'(job_r.day);
            data_flag            <= |clamp;
        end
    end

    // ====================
    // Warning and output
    // ====================
    assign date_before = (cur_job.month < cur_job.rec.month)
                      || (cur_job.month == cur_job.rec.month && cur_job.day < cur_job.rec.day);
    assign date_warn = (cur_job.action == Index_Check || cur_job.action == Check_Valid_Date)
                    && date_before;
    assign data_warn = (cur_job.action == Update) && data_flag;
    assign risk_warn = (cur_job.action == Index_Check) && (result_r >= thresh_r);

    // Date first, then data, then risk
    always_comb begin
        if (date_warn)
            warn_nx = Date_Warn;
        else if (data_warn)
            warn_nx = Data_Warn;
        else if (risk_warn)
            warn_nx = Risk_Warn;
        else
            warn_nx = No_Warn;
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            out_valid <= 1'b0;
            warn_msg  <= No_Warn;
            complete  <= 1'b0;
        end else begin
            out_valid <= fire;
            warn_msg  <= fire ? warn_nx : No_Warn;
            complete  <= fire && (warn_nx == No_Warn);
        end
    end

endmodule

/* job_queue.sv */
`timescale 1ns/10ps

module job_queue (
    input  logic            clk,
    input  logic            inf,
    input  logic            push_valid,
    input  stock_pkg::job_t push_job,
    output logic            full,
    input  logic            pop_ready,
    output stock_pkg::job_t pop_job,
    output logic            empty
);

    import stock_pkg::*;

    job_t       mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       do_push;
    logic       do_pop;

    assign full    = (count == 2'd2);
    assign empty   = (count == 2'd0);
    assign do_push = push_valid && !full;
    assign do_pop  = pop_ready && !empty;
    assign pop_job = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_job;
    end

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_push)
                wr_ptr <= ~wr_ptr;
            if (do_pop)
                rd_ptr <= ~rd_ptr;
            // Push and pop together leave the count
            count <= count + 2'(do_push) - 2'(do_pop);
        end
    end

endmodule

/* project.f */
stock_pkg.sv
sort4_pipe.sv
request_collector.sv
job_queue.sv
job_evaluator.sv
stock_top.sv
tb_clock.sv
tb_stock.sv

/* request_collector.sv */
`timescale 1ns/10ps

module request_collector (
    input  logic                             clk,
    input  logic                             inf,
    input  logic                             sel_action_valid,
    input  logic                             formula_valid,
    input  logic                             mode_valid,
    input  logic                             date_valid,
    input  logic                             data_no_valid,
    input  logic                             index_valid,
    input  stock_pkg::action_t               action,
    input  stock_pkg::formula_t              formula,
    input  stock_pkg::mode_t                 mode,
    input  logic [stock_pkg::MONTH_W-1:0]    month,
    input  logic [stock_pkg::DAY_W-1:0]      day,
    input  logic [stock_pkg::DATA_NO_W-1:0]  data_no,
    input  logic [stock_pkg::INDEX_W-1:0]    index,
    input  logic                             dram_rsp_valid,
    input  stock_pkg::record_t               dram_rsp_data,
    output logic                             dram_rd_valid,
    output logic [stock_pkg::ADDR_W-1:0]     dram_rd_addr,
    output logic                             accept_ready,
    output logic                             push_valid,
    output stock_pkg::job_t                  push_job,
    input  logic                             full
);

    import stock_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_COLLECT,
        S_WAIT_REC,
        S_PUSH
    } state_t;

    state_t     state, state_nx;
    job_t       job_q;
    logic [1:0] idx_cnt;
    logic       rec_done;
    logic       coll_last;

    // Last strobe of the request
    assign coll_last = (job_q.action == Update) ? (index_valid && idx_cnt == 2'd3)
                                                : data_no_valid;

    // ====================
    // FSM
    // ====================
    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (sel_action_valid)
                    state_nx = S_COLLECT;
            end
            S_COLLECT: begin
                if (coll_last)
                    state_nx = (rec_done || dram_rsp_valid) ? S_PUSH : S_WAIT_REC;
            end
            S_WAIT_REC: begin
                if (dram_rsp_valid)
                    state_nx = S_PUSH;
            end
            S_PUSH: begin
                if (!full)
                    state_nx = S_IDLE;
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state <= S_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    assign accept_ready = (state == S_IDLE);
    assign push_valid   = (state == S_PUSH);
    assign push_job     = job_q;

    // ====================
    // Field capture
    // ====================
    always_ff @(posedge clk) begin
        if (sel_action_valid)
            job_q.action <= action;
        if (formula_valid)
            job_q.formula <= formula;
        if (mode_valid)
            job_q.mode <= mode;
        if (date_valid) begin
            job_q.month <= month;
            job_q.day   <= day;
        end
        if (data_no_valid)
            job_q.data_no <= data_no;
        if (index_valid)
            job_q.delta[idx_cnt] <= index;
        if (dram_rsp_valid)
            job_q.rec <= dram_rsp_data;
    end

    // Index strobes are counted for Update only
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            idx_cnt <= 2'd0;
        end else if (state == S_IDLE) begin
            idx_cnt <= 2'd0;
        end else if (index_valid) begin
            idx_cnt <= idx_cnt + 2'd1;
        end
    end

    // Record may arrive before the last index
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            rec_done <= 1'b0;
        end else if (state == S_PUSH && !full) begin
            rec_done <= 1'b0;
        end else if (dram_rsp_valid) begin
            rec_done <= 1'b1;
        end
    end

    // ====================
    // Memory read
    // ====================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            dram_rd_valid <= 1'b0;
        end else begin
            dram_rd_valid <= data_no_valid;
        end
    end

    assign dram_rd_addr = rec_addr(job_q.data_no);

endmodule

/* sort4_pipe.sv */
`timescale 1ns/10ps

module sort4_pipe (
    input  logic        clk,
    input  logic [11:0] in_a,
    input  logic [11:0] in_b,
    input  logic [11:0] in_c,
    input  logic [11:0] in_d,
    output logic [11:0] out_max,
    output logic [11:0] out_2,
    output logic [11:0] out_3,
    output logic [11:0] out_min
);

    logic [11:0] p0_max, p0_min;
    logic [11:0] p1_max, p1_min;
    logic [11:0] top, bot, lo_max, hi_min;

    // ====================
    // Stage 1
    // ====================
    // Sort each input pair
    always_ff @(posedge clk) begin
        p0_max <= (in_a > in_b) ? in_a : in_b;
        p0_min <= (in_a > in_b) ? in_b : in_a;
        p1_max <= (in_c > in_d) ? in_c : in_d;
        p1_min <= (in_c > in_d) ? in_d : in_c;
    end

    // ====================
    // Stage 2
    // ====================
    // Maxima give the overall max, minima the overall min
    always_ff @(posedge clk) begin
        top    <= (p0_max > p1_max) ? p0_max : p1_max;
        lo_max <= (p0_max > p1_max) ? p1_max : p0_max;
        bot    <= (p0_min < p1_min) ? p0_min : p1_min;
        hi_min <= (p0_min < p1_min) ? p1_min : p0_min;
    end

    // ====================
    // Stage 3
    // ====================
    // Losers of stage 2 still need ordering
    always_ff @(posedge clk) begin
        out_max <= top;
        out_min <= bot;
        out_2   <= (lo_max > hi_min) ? lo_max : hi_min;
        out_3   <= (lo_max > hi_min) ? hi_min : lo_max;
    end

endmodule

/* stock_pkg.sv */
package stock_pkg;

    // ====================
    // Widths and constants
    // ====================
    localparam int INDEX_W   = 12;
    localparam int MONTH_W   = 4;
    localparam int DAY_W     = 5;
    localparam int DATA_NO_W = 8;
    localparam int ADDR_W    = 17;
    localparam int REC_W     = 64;

    localparam logic [ADDR_W-1:0]  DRAM_BASE = 17'h10000;
    localparam logic [INDEX_W-1:0] INDEX_MAX = 12'd4095;

    // Indexed by mode in the order Insensitive, Normal, Sensitive
    localparam logic [2:0][INDEX_W-1:0] THRESH_AC = {12'd511, 12'd1023, 12'd2047};
    localparam logic [2:0][INDEX_W-1:0] THRESH_B  = {12'd200, 12'd400, 12'd800};

    // ====================
    // Encodings
    // ====================
    typedef enum logic [1:0] {
        Index_Check      = 2'd0,
        Update           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        Formula_A = 3'd0,
        Formula_B = 3'd1,
        Formula_C = 3'd2
    } formula_t;

    typedef enum logic [1:0] {
        Insensitive = 2'd0,
        Normal      = 2'd1,
        Sensitive   = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        No_Warn   = 2'd0,
        Date_Warn = 2'd1,
        Data_Warn = 2'd2,
        Risk_Warn = 2'd3
    } warn_t;

    // ====================
    // Record and job
    // ====================
    // Memory layout with the MSB first
    typedef struct packed {
        logic [INDEX_W-1:0] index_a;
        logic [INDEX_W-1:0] index_b;
        logic [7:0]         month;
        logic [INDEX_W-1:0] index_c;
        logic [INDEX_W-1:0] index_d;
        logic [7:0]         day;
    } record_t;

    // Delta element 0 belongs to index A
    typedef struct packed {
        action_t                 action;
        formula_t                formula;
        mode_t                   mode;
        logic [MONTH_W-1:0]      month;
        logic [DAY_W-1:0]        day;
        logic [DATA_NO_W-1:0]    data_no;
        logic [3:0][INDEX_W-1:0] delta;
        record_t                 rec;
    } job_t;

    // Record address from data number
    function automatic logic [ADDR_W-1:0] rec_addr(input logic [DATA_NO_W-1:0] no);
        return DRAM_BASE + {no, 3'b000};
    endfunction

endpackage

/* stock_tests.txt */
# name action formula mode month day data_no delta_a delta_b delta_c delta_d record warn complete
# action 0 index check, 1 update, 2 check date; record and trailing write data in hex
ic_a_ins_low 0 0 0 12 31 5 0 0 0 0 0640C80612C1900F 0 1 0
ic_a_ins_high 0 0 0 12 31 17 0 0 0 0 FA0BB8037D03E80A 3 0 0
cvd_before 2 0 0 6 14 5 0 0 0 0 0640C80612C1900F 1 0 0
ic_a_nor_high 0 0 1 12 31 17 0 0 0 0 FA0BB8037D03E80A 3 0 0
upd_plain 1 0 0 1 2 5 10 -20 30 -40 0640C80612C1900F 0 1 06E0B40114A16802
ic_a_sen_below 0 0 2 12 31 200 0 0 0 0 258208011F41A401 0 1 0
ic_a_sen_equal 0 0 2 12 31 255 0 0 0 0 1FF1FF021FF1FF05 3 0 0
cvd_equal 2 0 0 6 15 5 0 0 0 0 0640C80612C1900F 0 1 0
ic_b_ins_high 0 1 0 12 31 17 0 0 0 0 FA0BB8037D03E80A 3 0 0
ic_b_nor_equal 0 1 1 12 31 0 0 0 0 0 3841F4042BC25814 3 0 0
upd_high 1 0 0 8 8 17 200 1000 -500 0 FA0BB8037D03E80A 2 0 FFFFA0085DC3E808
ic_b_sen_low 0 1 2 12 31 200 0 0 0 0 258208011F41A401 0 1 0
ic_b_sen_high 0 1 2 12 31 5 0 0 0 0 0640C80612C1900F 3 0 0
cvd_later 2 0 0 4 1 17 0 0 0 0 FA0BB8037D03E80A 0 1 0
ic_c_ins_low 0 2 0 12 31 17 0 0 0 0 FA0BB8037D03E80A 0 1 0
ic_c_nor_equal 0 2 1 12 31 99 0 0 0 0 44C4B0053FF51409 3 0 0
upd_low 1 0 0 11 30 200 -700 -520 -2048 2047 258208011F41A401 2 0 0000000B0009A31E
ic_date_first 0 0 0 3 9 17 0 0 0 0 FA0BB8037D03E80A 1 0 0
cvd_month 2 0 0 3 31 0 0 0 0 0 3841F4042BC25814 1 0 0
ic_c_sen_low 0 2 2 12 31 200 0 0 0 0 258208011F41A401 0 1 0
upd_edge 1 0 0 12 31 255 2047 2047 -511 0 1FF1FF021FF1FF05 0 1 9FE9FE0C0001FF1F
upd_max 1 0 0 3 10 17 95 0 0 0 FA0BB8037D03E80A 0 1 FFFBB8037D03E80A

/* stock_top.sv */
`timescale 1ns/10ps

module stock_top (
    input  logic                             clk,
    input  logic                             inf,
    input  logic                             sel_action_valid,
    input  logic                             formula_valid,
    input  logic                             mode_valid,
    input  logic                             date_valid,
    input  logic                             data_no_valid,
    input  logic                             index_valid,
    input  stock_pkg::action_t               action,
    input  stock_pkg::formula_t              formula,
    input  stock_pkg::mode_t                 mode,
    input  logic [stock_pkg::MONTH_W-1:0]    month,
    input  logic [stock_pkg::DAY_W-1:0]      day,
    input  logic [stock_pkg::DATA_NO_W-1:0]  data_no,
    input  logic [stock_pkg::INDEX_W-1:0]    index,
    input  logic                             dram_rsp_valid,
    input  stock_pkg::record_t               dram_rsp_data,
    output logic                             dram_rd_valid,
    output logic [stock_pkg::ADDR_W-1:0]     dram_rd_addr,
    output logic                             dram_wr_valid,
    output logic [stock_pkg::ADDR_W-1:0]     dram_wr_addr,
    output stock_pkg::record_t               dram_wr_data,
    output logic                             accept_ready,
    output logic                             out_valid,
    output stock_pkg::warn_t                 warn_msg,
    output logic                             complete
);

    import stock_pkg::*;

    logic push_valid;
    job_t push_job;
    logic full;
    logic pop_ready;
    job_t pop_job;
    logic empty;

    // Producer side
    request_collector collector_i (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .formula_valid    (formula_valid),
        .mode_valid       (mode_valid),
        .date_valid       (date_valid),
        .data_no_valid    (data_no_valid),
        .index_valid      (index_valid),
        .action           (action),
        .formula          (formula),
        .mode             (mode),
        .month            (month),
        .day              (day),
        .data_no          (data_no),
        .index            (index),
        .dram_rsp_valid   (dram_rsp_valid),
        .dram_rsp_data    (dram_rsp_data),
        .dram_rd_valid    (dram_rd_valid),
        .dram_rd_addr     (dram_rd_addr),
        .accept_ready     (accept_ready),
        .push_valid       (push_valid),
        .push_job         (push_job),
        .full             (full)
    );

    job_queue queue_i (
        .clk        (clk),
        .inf        (inf),
        .push_valid (push_valid),
        .push_job   (push_job),
        .full       (full),
        .pop_ready  (pop_ready),
        .pop_job    (pop_job),
        .empty      (empty)
    );

    // Consumer side
    job_evaluator evaluator_i (
        .clk           (clk),
        .inf           (inf),
        .pop_job       (pop_job),
        .empty         (empty),
        .pop_ready     (pop_ready),
        .dram_wr_valid (dram_wr_valid),
        .dram_wr_addr  (dram_wr_addr),
        .dram_wr_data  (dram_wr_data),
        .out_valid     (out_valid),
        .warn_msg      (warn_msg),
        .complete      (complete)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic inf
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset low for two cycles and released on a falling edge
    initial begin
        inf = 1'b0;
        repeat (2) @(negedge clk);
        inf = 1'b1;
    end

endmodule

/* tb_stock.sv */
`timescale 1ns/10ps

module tb_stock;

    import stock_pkg::*;

    localparam int MAX_TESTS = 64;

    logic                 clk;
    logic                 inf;
    logic                 sel_action_valid, formula_valid, mode_valid;
    logic                 date_valid, data_no_valid, index_valid;
    action_t              action;
    formula_t             formula;
    mode_t                mode;
    logic [MONTH_W-1:0]   month;
    logic [DAY_W-1:0]     day;
    logic [DATA_NO_W-1:0] data_no;
    logic [INDEX_W-1:0]   index;
    logic                 dram_rsp_valid;
    record_t              dram_rsp_data;
    logic                 dram_rd_valid, dram_wr_valid;
    logic [ADDR_W-1:0]    dram_rd_addr, dram_wr_addr;
    record_t              dram_wr_data;
    logic                 accept_ready, out_valid, complete;
    warn_t                warn_msg;

    // Test table
    string            t_name [MAX_TESTS];
    int               t_action [MAX_TESTS];
    int               t_formula [MAX_TESTS];
    int               t_mode [MAX_TESTS];
    int               t_month [MAX_TESTS];
    int               t_day [MAX_TESTS];
    int               t_data_no [MAX_TESTS];
    int               t_delta [MAX_TESTS][4];
    logic [REC_W-1:0] t_rec [MAX_TESTS];
    int               t_warn [MAX_TESTS];
    int               t_complete [MAX_TESTS];
    logic [REC_W-1:0] t_wr [MAX_TESTS];
    int               n_tests = 0;

    // Requests in flight
    int          issue_q[$];
    int          result_q[$];
    int          rsp_q[$];
    int          due_q[$];

    int          n_results = 0;
    int          cycles = 0;
    int          limit = 1000000;
    logic [31:0] gap_state = 32'd12;
    logic [31:0] delay_state = 32'd12;

    tb_clock clock_i (
        .clk (clk),
        .inf (inf)
    );

    stock_top dut_i (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .formula_valid    (formula_valid),
        .mode_valid       (mode_valid),
        .date_valid       (date_valid),
        .data_no_valid    (data_no_valid),
        .index_valid      (index_valid),
        .action           (action),
        .formula          (formula),
        .mode             (mode),
        .month            (month),
        .day              (day),
        .data_no          (data_no),
        .index            (index),
        .dram_rsp_valid   (dram_rsp_valid),
        .dram_rsp_data    (dram_rsp_data),
        .dram_rd_valid    (dram_rd_valid),
        .dram_rd_addr     (dram_rd_addr),
        .dram_wr_valid    (dram_wr_valid),
        .dram_wr_addr     (dram_wr_addr),
        .dram_wr_data     (dram_wr_data),
        .accept_ready     (accept_ready),
        .out_valid        (out_valid),
        .warn_msg         (warn_msg),
        .complete         (complete)
    );

    // ====================
    // Helpers
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Strobe spacing of 1 to 8 cycles
    task automatic idle_gap();
        int n;
        gap_state = xorshift32(gap_state);
        n = gap_state % 8;
        repeat (n) @(negedge clk);
    endtask

    task automatic send_request(input int t);
        while (!accept_ready)
            @(negedge clk);
        result_q.push_back(t);
        sel_action_valid = 1'b1;
        action = action_t'(2'(t_action[t]));
        @(negedge clk);
        sel_action_valid = 1'b0;
        assert (!accept_ready)
            else abort_run("accept_ready stayed high after the action strobe");
        if (t_action[t] == 0) begin
            idle_gap();
            formula_valid = 1'b1;
            formula = formula_t'(3'(t_formula[t]));
            @(negedge clk);
            formula_valid = 1'b0;
            idle_gap();
            mode_valid = 1'b1;
            mode = mode_t'(2'(t_mode[t]));
            @(negedge clk);
            mode_valid = 1'b0;
        end
        idle_gap();
        date_valid = 1'b1;
        month = 4'(t_month[t]);
        day = 5'(t_day[t]);
        @(negedge clk);
        date_valid = 1'b0;
        idle_gap();
        data_no_valid = 1'b1;
        data_no = 8'(t_data_no[t]);
        issue_q.push_back(t);
        @(negedge clk);
        data_no_valid = 1'b0;
        // Deltas A to D follow for Update
        if (t_action[t] == 1) begin
            for (int i = 0; i < 4; i++) begin
                idle_gap();
                index_valid = 1'b1;
                index = 12'(t_delta[t][i]);
                @(negedge clk);
                index_valid = 1'b0;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin : main
        int    fd;
        int    code;
        string line;
        sel_action_valid = 1'b0;
        formula_valid = 1'b0;
        mode_valid = 1'b0;
        date_valid = 1'b0;
        data_no_valid = 1'b0;
        index_valid = 1'b0;
        action = Index_Check;
        formula = Formula_A;
        mode = Insensitive;
        month = '0;
        day = '0;
        data_no = '0;
        index = '0;
        dram_rsp_valid = 1'b0;
        dram_rsp_data = '0;

        fd = $fopen("stock_tests.txt", "r");
        assert (fd != 0) else abort_run("Could not open stock_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            assert (n_tests < MAX_TESTS) else abort_run("Too many lines in the test file");
            code = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %h %d %d %h",
                           t_name[n_tests], t_action[n_tests], t_formula[n_tests],
                           t_mode[n_tests], t_month[n_tests], t_day[n_tests],
                           t_data_no[n_tests], t_delta[n_tests][0], t_delta[n_tests][1],
                           t_delta[n_tests][2], t_delta[n_tests][3], t_rec[n_tests],
                           t_warn[n_tests], t_complete[n_tests], t_wr[n_tests]);
            assert (code == 15) else abort_run($sformatf("Malformed test line: %s", line));
            n_tests++;
        end
        $fclose(fd);
        assert (n_tests > 0) else abort_run("The test file holds no tests");
        limit = n_tests * 80 + 100;

        wait (inf === 1'b1);
        @(negedge clk);
        for (int t = 0; t < n_tests; t++)
            send_request(t);

        while (n_results < n_tests)
            @(negedge clk);
        // Catch any stray result
        repeat (20) @(negedge clk);
        if (n_results == n_tests && result_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("Got %0d results for %0d tests", n_results, n_tests));
        end
    end

    // ====================
    // Memory model
    // ====================
    initial begin : memory_model
        int t;
        int d;
        forever begin
            @(negedge clk);
            dram_rsp_valid = 1'b0;
            if (dram_rd_valid) begin
                assert (issue_q.size() > 0)
                    else abort_run("Memory read issued with no request outstanding");
                t = issue_q.pop_front();
                assert (dram_rd_addr == DRAM_BASE + 17'(t_data_no[t] * 8))
                    else abort_run($sformatf("Mismatch in %s: dram_rd_addr expected %h, actual %h",
                                             t_name[t], DRAM_BASE + 17'(t_data_no[t] * 8),
                                             dram_rd_addr));
                delay_state = xorshift32(delay_state);
                d = delay_state % 8 + 1;
                rsp_q.push_back(t);
                due_q.push_back(cycles + d);
            end
            if (rsp_q.size() > 0 && cycles >= due_q[0]) begin
                t = rsp_q.pop_front();
                void'(due_q.pop_front());
                dram_rsp_valid = 1'b1;
                dram_rsp_data = t_rec[t];
            end
        end
    end

    // ====================
    // Result checker
    // ====================
    initial begin : result_monitor
        int t;
        bit wr_seen;
        wr_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (dram_wr_valid) begin
                assert (result_q.size() > 0 && t_action[result_q[0]] == 1)
                    else abort_run("Memory write issued for a request that is not an update");
                t = result_q[0];
                assert (dram_wr_addr == DRAM_BASE + 17'(t_data_no[t] * 8))
                    else abort_run($sformatf("Mismatch in %s: dram_wr_addr expected %h, actual %h",
                                             t_name[t], DRAM_BASE + 17'(t_data_no[t] * 8),
                                             dram_wr_addr));
                assert (64'(dram_wr_data) == t_wr[t])
                    else abort_run($sformatf("Mismatch in %s: dram_wr_data expected %h, actual %h",
                                             t_name[t], t_wr[t], 64'(dram_wr_data)));
                wr_seen = 1'b1;
            end
            if (out_valid) begin
                assert (result_q.size() > 0)
                    else abort_run("A result arrived with no request outstanding");
                t = result_q.pop_front();
                assert (int'(warn_msg) == t_warn[t])
                    else abort_run($sformatf("Mismatch in %s: warn_msg expected %0d, actual %0d",
                                             t_name[t], t_warn[t], warn_msg));
                assert (int'(complete) == t_complete[t])
                    else abort_run($sformatf("Mismatch in %s: complete expected %0d, actual %0d",
                                             t_name[t], t_complete[t], complete));
                assert (wr_seen == (t_action[t] == 1))
                    else abort_run($sformatf("In %s the memory write was missing or unexpected",
                                             t_name[t]));
                wr_seen = 1'b0;
                n_results++;
            end
        end
    end

    // Cycle limit
    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycles++;
            assert (cycles < limit)
                else abort_run($sformatf("Timeout after %0d cycles, the run hung", cycles));
        end
    end

endmodule
